// ==== compile.f ====
logic/mera_pkg.sv
logic/pwr_seq.sv
logic/seg_map.sv
logic/mem_array.sv
logic/mem_ctrl.sv
logic/mera_mem_top.sv
verification/mem_checker.sv
verification/mem_props.sv
verification/tb_mera_mem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mera_mem
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== verification/mem_tests.txt ====
# req name op nb ad dt exp_ok exp_en exp_dt gap (hex fields, gap = idle cycles after, decimal)
# clr name
req rd_nomap      rd  0 1010 0000 0 1 0000 2
req set_b0_p1     set 0 1000 8003 1 0 0000 2
req wr_b0_p1      wr  0 1010 a5a5 1 0 0000 2
req rd_b0_p1      rd  0 1010 0000 1 0 a5a5 2
req set_b1_p1     set 1 1000 8005 1 0 0000 1
req wr_b1_p1      wr  1 1010 5555 1 0 0000 1
req rd_b0_sep     rd  0 1010 0000 1 0 a5a5 0
req rd_b1_sep     rd  1 1010 0000 1 0 5555 2
req set_b2_p2     set 2 2000 8003 1 0 0000 0
req rd_b2_share   rd  2 2010 0000 1 0 a5a5 0
req wr_b2_share   wr  2 2010 1234 1 0 0000 0
req rd_b0_share   rd  0 1010 0000 1 0 1234 2
req set_b3_p4     set 3 4000 8007 1 0 0000 0
req wr_b3_p4      wr  3 4020 beef 1 0 0000 0
req rd_b3_p4      rd  3 4020 0000 1 0 beef 2
req set_b3_p5_off set 3 5000 0007 1 0 0000 0
req wr_b3_p5      wr  3 5020 dead 0 1 0000 0
req rd_b3_p5      rd  3 5020 0000 0 1 0000 0
req rd_b3_old     rd  3 4020 0000 1 0 beef 2
clr clear_1
req rd_b0_clr     rd  0 1010 0000 0 1 0000 0
req set_b0_again  set 0 1000 8003 1 0 0000 0
req rd_b0_kept    rd  0 1010 0000 1 0 1234 2

// ==== verification/tb_mera_mem.sv ====
`timescale 1ns/1ps

module tb_mera_mem;

	import mera_pkg::*;

	// cycles any single wait may take
	localparam int WAIT_LIMIT = 200;
	localparam int W_PON      = 0;
	localparam int W_CLM      = 1;
	localparam int W_REPLIES  = 2;

	logic     clk_sys = 1'b0;
	logic     rst_n;
	logic     dcl;
	bus_req_t req;
	logic     req_stb;
	bus_rsp_t rsp;
	logic     rsp_stb;
	logic     pon;
	logic     clm;

	int rsp_cnt;
	int mis_cnt;
	int misc_cnt;
	int req_cnt = 0;
	int drv_err = 0;
	int total_err;

	always #50 clk_sys = ~clk_sys;

	mera_mem_top DUT (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.dcl     (dcl),
		.req     (req),
		.req_stb (req_stb),
		.rsp     (rsp),
		.rsp_stb (rsp_stb),
		.pon     (pon),
		.clm     (clm)
	);

	mem_checker CHK (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.rsp      (rsp),
		.rsp_stb  (rsp_stb),
		.pon      (pon),
		.clm      (clm),
		.rsp_cnt  (rsp_cnt),
		.mis_cnt  (mis_cnt),
		.misc_cnt (misc_cnt)
	);

	function automatic logic cond_met(input int which);
		case (which)
			W_PON:   return pon;
			W_CLM:   return clm;
			default: return rsp_cnt == req_cnt;
		endcase
	endfunction

	// poll once per cycle until the condition holds or time runs out
	task automatic wait_until(input int which, input string what);
		int n;
		n = 0;
		while (!cond_met(which) && n < WAIT_LIMIT) begin
			@(posedge clk_sys);
			n++;
		end
		if (!cond_met(which)) begin
			$display("timeout waiting for %0s", what);
			drv_err++;
		end
		@(posedge clk_sys);
		#1;
	endtask

	function automatic bus_op_t op_code(input logic [8*8-1:0] s);
		if (s == "wr") return op_write;
		if (s == "rd") return op_read;
		if (s == "set") return op_set;
		return op_none;
	endfunction

	// ------------------------------
	// bus master side
	// ------------------------------
	// called at posedge + 1, leaves at posedge + 1
	task automatic send_req(input bus_op_t op, input logic [NB_W-1:0] nb,
		input logic [WORD_W-1:0] ad, input logic [WORD_W-1:0] dt, input int gap);
		req.op  = op;
		req.nb  = nb;
		req.ad  = ad;
		req.dt  = dt;
		req_stb = 1'b1;
		@(posedge clk_sys);
		#1;
		req_stb = 1'b0;
		req_cnt++;
		repeat (gap) begin
			@(posedge clk_sys);
			#1;
		end
	endtask

	task automatic pulse_clear();
		// drain in-flight replies first
		wait_until(W_REPLIES, "replies before clear");
		dcl = 1'b1;
		@(posedge clk_sys);
		#1;
		dcl = 1'b0;
		wait_until(W_CLM, "clm to rise");
		wait_until(W_PON, "pon to return after clear");
	endtask

	initial begin
		int fd;
		int c;
		int gap;
		logic [8*8-1:0]    kind;
		logic [8*24-1:0]   name;
		logic [8*8-1:0]    op_s;
		logic [NB_W-1:0]   nb;
		logic [WORD_W-1:0] ad;
		logic [WORD_W-1:0] dt;
		logic              ok;
		logic              en;
		logic [WORD_W-1:0] edt;
		rst_n   = 1'b0;
		dcl     = 1'b0;
		req     = '0;
		req_stb = 1'b0;
		repeat (16) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		if (pon || clm) begin
			$display("pon or clm high right after reset");
			drv_err++;
		end
		wait_until(W_PON, "pon after reset");

		fd = $fopen("verification/mem_tests.txt", "r");
		if (fd == 0) begin
			$display("driver cannot open verification/mem_tests.txt");
			drv_err++;
		end else begin
			while ($fscanf(fd, "%s", kind) == 1) begin
				if (kind == "req") begin
					c = $fscanf(fd, "%s %s %h %h %h %h %h %h %d",
						name, op_s, nb, ad, dt, ok, en, edt, gap);
					send_req(op_code(op_s), nb, ad, dt, gap);
				end else if (kind == "clr") begin
					c = $fscanf(fd, "%s", name);
					pulse_clear();
				end else begin
					c = $fgetc(fd);
					while (c != 10 && c != -1) begin
						c = $fgetc(fd);
					end
				end
			end
			$fclose(fd);
		end

		wait_until(W_REPLIES, "all replies");
		repeat (4) @(posedge clk_sys);
		total_err = mis_cnt + misc_cnt + drv_err + DUT.PROPS.fail_cnt;
		$display("errors: %0d mismatch, %0d checker, %0d driver, %0d assertion",
			mis_cnt, misc_cnt, drv_err, DUT.PROPS.fail_cnt);
		if (total_err == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== verification/mem_props.sv ====
`timescale 1ns/1ps

module mem_props (
	input logic clk_sys,
	input logic rst_n,
	input logic req_stb,
	input logic rsp_stb,
	input logic pon,
	input logic clm
);

	import mera_pkg::*;

	// failed properties so far
	int fail_cnt = 0;

	// reply exactly REPLY_LAT cycles after an accepted strobe and never otherwise
	reply_lat_a: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rsp_stb == $past(req_stb && pon, REPLY_LAT))
	else begin
		$error("reply strobe not REPLY_LAT cycles after an accepted request");
		fail_cnt++;
	end

	// pon excludes clm and only comes back after a full clear pulse
	pon_clm_a: assert property (@(posedge clk_sys) disable iff (!rst_n)
		pon |-> !clm && ($past(pon) || ($past(clm) && $past(clm, CLEAR_TICKS)
			&& !$past(clm, CLEAR_TICKS + 1))))
	else begin
		$error("pon overlaps clm or rose without a full clear pulse");
		fail_cnt++;
	end

	// quiet reply port in reset
	reset_quiet_a: assert property (@(posedge clk_sys) !rst_n |-> !rsp_stb)
	else begin
		$error("reply strobe high during reset");
		fail_cnt++;
	end

endmodule

bind mera_mem_top mem_props PROPS (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.req_stb (req_stb),
	.rsp_stb (rsp_stb),
	.pon     (pon),
	.clm     (clm)
);

// ==== verification/mem_checker.sv ====
`timescale 1ns/1ps

module mem_checker (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  mera_pkg::bus_rsp_t rsp,
	input  logic               rsp_stb,
	input  logic               pon,
	input  logic               clm,
	output int                 rsp_cnt,
	output int                 mis_cnt,
	output int                 misc_cnt
);

	import mera_pkg::*;

	// expected replies in request order
	bus_rsp_t          exp_q [$];
	logic [8*24-1:0]   name_q [$];
	bus_rsp_t          exp_rsp;
	logic [8*24-1:0]   exp_name;

	// ------------------------------
	// load expected replies
	// ------------------------------
	initial begin
		int fd;
		int c;
		int gap;
		logic [8*8-1:0]    kind;
		logic [8*24-1:0]   name;
		logic [8*8-1:0]    op_s;
		logic [NB_W-1:0]   nb;
		logic [WORD_W-1:0] ad;
		logic [WORD_W-1:0] dt;
		logic              ok;
		logic              en;
		logic [WORD_W-1:0] edt;
		fd = $fopen("verification/mem_tests.txt", "r");
		if (fd == 0) begin
			$display("checker cannot open verification/mem_tests.txt");
		end else begin
			while ($fscanf(fd, "%s", kind) == 1) begin
				if (kind == "req") begin
					c = $fscanf(fd, "%s %s %h %h %h %h %h %h %d",
						name, op_s, nb, ad, dt, ok, en, edt, gap);
					exp_q.push_back({ok, en, edt});
					name_q.push_back(name);
				end else if (kind == "clr") begin
					// no reply for a clear
					c = $fscanf(fd, "%s", name);
				end else begin
					// comment, drop the rest of the line
					c = $fgetc(fd);
					while (c != 10 && c != -1) begin
						c = $fgetc(fd);
					end
				end
			end
			$fclose(fd);
		end
	end

	// outputs settle well before the falling edge
	always @(negedge clk_sys) begin
		if (!rst_n && (pon || clm)) begin
			$display("pon or clm high during reset");
			misc_cnt++;
		end
		if (rst_n && rsp_stb) begin
			if (exp_q.size() == 0) begin
				$display("reply seen with no request left in the test list");
				misc_cnt++;
			end else begin
				exp_rsp  = exp_q.pop_front();
				exp_name = name_q.pop_front();
				if (rsp !== exp_rsp) begin
					$display("[FAIL] %0s expected ok=%b en=%b dt=%h actual ok=%b en=%b dt=%h",
						exp_name, exp_rsp.ok, exp_rsp.en, exp_rsp.dt,
						rsp.ok, rsp.en, rsp.dt);
					mis_cnt++;
				end
			end
			rsp_cnt++;
		end
	end

endmodule

// ==== logic/mera_mem_top.sv ====
`timescale 1ns/1ps

module mera_mem_top (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               dcl,
	input  mera_pkg::bus_req_t req,
	input  logic               req_stb,
	output mera_pkg::bus_rsp_t rsp,
	output logic               rsp_stb,
	output logic               pon,
	output logic               clm
);

	import mera_pkg::*;

	// controller to map
	logic              set_stb;
	logic [NB_W-1:0]   set_nb;
	logic [PAGE_W-1:0] set_page;
	map_entry_t        set_entry;
	logic [NB_W-1:0]   look_nb;
	logic [PAGE_W-1:0] look_page;
	map_entry_t        look_entry;
	// controller to array
	logic [ARR_AW-1:0] arr_addr;
	logic              arr_we;
	logic [WORD_W-1:0] arr_wdata;
	logic [WORD_W-1:0] arr_rdata;

	// ------------------------------
	// power and clear
	// ------------------------------
	pwr_seq SEQ (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.dcl     (dcl),
		.pon     (pon),
		.clm     (clm)
	);

	// ------------------------------
	// memory module
	// ------------------------------
	mem_ctrl CTRL (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.pon        (pon),
		.req        (req),
		.req_stb    (req_stb),
		.rsp        (rsp),
		.rsp_stb    (rsp_stb),
		.set_stb    (set_stb),
		.set_nb     (set_nb),
		.set_page   (set_page),
		.set_entry  (set_entry),
		.look_nb    (look_nb),
		.look_page  (look_page),
		.look_entry (look_entry),
		.arr_addr   (arr_addr),
		.arr_we     (arr_we),
		.arr_wdata  (arr_wdata),
		.arr_rdata  (arr_rdata)
	);

	seg_map MAP (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.clm        (clm),
		.set_stb    (set_stb),
		.set_nb     (set_nb),
		.set_page   (set_page),
		.set_entry  (set_entry),
		.look_nb    (look_nb),
		.look_page  (look_page),
		.look_entry (look_entry)
	);

	mem_array ARR (
		.clk_sys (clk_sys),
		.addr    (arr_addr),
		.we      (arr_we),
		.wdata   (arr_wdata),
		.rdata   (arr_rdata)
	);

endmodule

// ==== logic/mem_ctrl.sv ====
`timescale 1ns/1ps

module mem_ctrl (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        pon,
	// system bus side
	input  mera_pkg::bus_req_t          req,
	input  logic                        req_stb,
	output mera_pkg::bus_rsp_t          rsp,
	output logic                        rsp_stb,
	// page map, set port
	output logic                        set_stb,
	output logic [mera_pkg::NB_W-1:0]   set_nb,
	output logic [mera_pkg::PAGE_W-1:0] set_page,
	output mera_pkg::map_entry_t        set_entry,
	// page map, lookup port
	output logic [mera_pkg::NB_W-1:0]   look_nb,
	output logic [mera_pkg::PAGE_W-1:0] look_page,
	input  mera_pkg::map_entry_t        look_entry,
	// word store
	output logic [mera_pkg::ARR_AW-1:0] arr_addr,
	output logic                        arr_we,
	output logic [mera_pkg::WORD_W-1:0] arr_wdata,
	input  logic [mera_pkg::WORD_W-1:0] arr_rdata
);

	import mera_pkg::*;

	// one stage valid per cycle of latency, last bit is the reply
	logic [REPLY_LAT-1:0] stb_pipe;
	bus_req_t             s1_req;
	bus_req_t             s2_req;
	logic                 s2_mem;
	logic                 s3_ok;
	logic                 s3_en;
	logic                 s3_rd;

	// requests only taken with power on, no reply for dropped ones
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			stb_pipe <= '0;
		end else begin
			stb_pipe <= {stb_pipe[REPLY_LAT-2:0], req_stb & pon};
		end
	end

	// request payload follows the strobe down the pipe
	always_ff @(posedge clk_sys) begin
		s1_req <= req;
		s2_req <= s1_req;
	end

	// ------------------------------
	// stage 1: map lookup and set
	// ------------------------------
	assign look_nb   = s1_req.nb;
	assign look_page = s1_req.ad[WORD_W-1 -: PAGE_W];

	// set lands at end of this cycle, next lookup sees it
	assign set_stb         = stb_pipe[0] && (s1_req.op == op_set);
	assign set_nb          = s1_req.nb;
	assign set_page        = s1_req.ad[WORD_W-1 -: PAGE_W];
	assign set_entry.valid = s1_req.dt[WORD_W-1];
	assign set_entry.frame = s1_req.dt[FRAME_W-1:0];

	// ------------------------------
	// stage 2: valid check, access
	// ------------------------------
	assign s2_mem = (s2_req.op == op_read) || (s2_req.op == op_write);

	// physical word = frame from map + offset from ad
	assign arr_addr  = {look_entry.frame, s2_req.ad[OFF_W-1:0]};
	// unmapped page, write is dropped
	assign arr_we    = stb_pipe[1] && (s2_req.op == op_write) && look_entry.valid;
	assign arr_wdata = s2_req.dt;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			s3_ok <= 1'b0;
			s3_en <= 1'b0;
			s3_rd <= 1'b0;
		end else begin
			// en only for memory ops on an invalid page
			s3_en <= stb_pipe[1] && s2_mem && !look_entry.valid;
			s3_ok <= stb_pipe[1] && !(s2_mem && !look_entry.valid);
			s3_rd <= stb_pipe[1] && (s2_req.op == op_read) && look_entry.valid;
		end
	end

	// ------------------------------
	// stage 3: reply
	// ------------------------------
	assign rsp_stb = stb_pipe[REPLY_LAT-1];
	assign rsp.ok  = s3_ok;
	assign rsp.en  = s3_en;
	// read data arrives from the array this cycle, zero otherwise
	assign rsp.dt  = s3_rd ? arr_rdata : '0;

endmodule

// ==== logic/mem_array.sv ====
`timescale 1ns/1ps

module mem_array (
	input  logic                        clk_sys,
	input  logic [mera_pkg::ARR_AW-1:0] addr,
	input  logic                        we,
	input  logic [mera_pkg::WORD_W-1:0] wdata,
	output logic [mera_pkg::WORD_W-1:0] rdata
);

	import mera_pkg::*;

	// all 16 frames of 256 words, stand-in for the external sram
	logic [WORD_W-1:0] mem [ARR_DEPTH];

	// single port, read-before-write on the same edge
	always_ff @(posedge clk_sys) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

// ==== logic/seg_map.sv ====
`timescale 1ns/1ps

module seg_map (
	input  logic                        clk_sys,
	input  logic                        rst_n,
	input  logic                        clm,
	// map update from set-segment
	input  logic                        set_stb,
	input  logic [mera_pkg::NB_W-1:0]   set_nb,
	input  logic [mera_pkg::PAGE_W-1:0] set_page,
	input  mera_pkg::map_entry_t        set_entry,
	// translation lookup
	input  logic [mera_pkg::NB_W-1:0]   look_nb,
	input  logic [mera_pkg::PAGE_W-1:0] look_page,
	output mera_pkg::map_entry_t        look_entry
);

	import mera_pkg::*;

	// valid bits kept as flops so clm can drop all of them at once
	logic [MAP_DEPTH-1:0] valid_q;
	// frame numbers in plain storage
	logic [FRAME_W-1:0]   frame_mem [MAP_DEPTH];

	logic [MAP_AW-1:0] set_idx;
	logic [MAP_AW-1:0] look_idx;

	assign set_idx  = {set_nb, set_page};
	assign look_idx = {look_nb, look_page};

	// ------------------------------
	// valid bits
	// ------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else if (clm) begin
			// clear wins over any late set
			valid_q <= '0;
		end else if (set_stb) begin
			valid_q[set_idx] <= set_entry.valid;
		end
	end

	// frame store and registered lookup
	always_ff @(posedge clk_sys) begin
		if (set_stb) begin
			frame_mem[set_idx] <= set_entry.frame;
		end
		look_entry.valid <= valid_q[look_idx];
		look_entry.frame <= frame_mem[look_idx];
	end

endmodule

// ==== logic/pwr_seq.sv ====
`timescale 1ns/1ps

module pwr_seq (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic dcl,
	output logic pon,
	output logic clm
);

	import mera_pkg::*;

	// counter sized for the longer of the two waits
	localparam int TICK_W = $clog2(POWER_UP_TICKS);

	typedef enum logic [1:0] {
		ST_OFF   = 2'd0,
		ST_CLEAR = 2'd1,
		ST_RUN   = 2'd2
	} seq_state_t;

	seq_state_t        state;
	logic [TICK_W-1:0] tick;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_OFF;
			tick  <= '0;
		end else begin
			case (state)
				// supply settling after reset
				ST_OFF: begin
					if (tick == TICK_W'(POWER_UP_TICKS - 1)) begin
						state <= ST_CLEAR;
						tick  <= '0;
					end else begin
						tick <= tick + 1'b1;
					end
				end
				// clm pulse, map gets wiped
				ST_CLEAR: begin
					if (tick == TICK_W'(CLEAR_TICKS - 1)) begin
						state <= ST_RUN;
						tick  <= '0;
					end else begin
						tick <= tick + 1'b1;
					end
				end
				// normal operation, dcl forces a new clear
				ST_RUN: begin
					if (dcl) begin
						state <= ST_CLEAR;
						tick  <= '0;
					end
				end
				default: begin
					state <= ST_OFF;
					tick  <= '0;
				end
			endcase
		end
	end

	// decoded straight from state, so never high together
	assign pon = (state == ST_RUN);
	assign clm = (state == ST_CLEAR);

endmodule

// ==== logic/mera_pkg.sv ====
package mera_pkg;

	// ------------------------------
	// bus and memory sizing
	// ------------------------------
	localparam int WORD_W  = 16;
	localparam int NB_W    = 4;
	// logical page from top of ad, word offset from the bottom
	localparam int PAGE_W  = 4;
	localparam int OFF_W   = 8;
	localparam int FRAME_W = 4;

	// map indexed by {nb, page}
	localparam int MAP_AW    = NB_W + PAGE_W;
	localparam int MAP_DEPTH = 2 ** MAP_AW;
	// physical store indexed by {frame, offset}
	localparam int ARR_AW    = FRAME_W + OFF_W;
	localparam int ARR_DEPTH = 2 ** ARR_AW;

	// sequencer timing, in clk_sys cycles
	localparam int POWER_UP_TICKS = 16;
	localparam int CLEAR_TICKS    = 4;

	// request strobe to reply strobe
	localparam int REPLY_LAT = 3;

	// ------------------------------
	// bus types
	// ------------------------------
	typedef enum logic [1:0] {
		op_none  = 2'd0,
		op_write = 2'd1,
		op_read  = 2'd2,
		op_set   = 2'd3
	} bus_op_t;

	typedef struct packed {
		bus_op_t             op;
		logic [NB_W-1:0]     nb;
		logic [WORD_W-1:0]   ad;
		logic [WORD_W-1:0]   dt;
	} bus_req_t;

	typedef struct packed {
		logic                ok;
		logic                en;
		logic [WORD_W-1:0]   dt;
	} bus_rsp_t;

	typedef struct packed {
		logic                valid;
		logic [FRAME_W-1:0]  frame;
	} map_entry_t;

endpackage
